/* cpu_pkg.sv */
package cpu_pkg;

	localparam int xlen = 32;
	localparam int reg_aw = 5;
	localparam int pc_w = 10;
	localparam int dm_aw = 12;

	// major opcode, instr[30:25]
	typedef enum logic [5:0] {
		alu_reg = 6'b100000,
		addi    = 6'b101000,
		movi    = 6'b100010,
		lwi     = 6'b000010,
		swi     = 6'b001010,
		beq     = 6'b100110,
		bne     = 6'b100111,
		j       = 6'b100100
	} opcode_e;

	// sub-op, instr[4:0]; op_pass is internal, used by movi
	typedef enum logic [4:0] {
		op_add  = 5'b00000,
		op_sub  = 5'b00001,
		op_and  = 5'b00010,
		op_xor  = 5'b00011,
		op_or   = 5'b00100,
		op_slli = 5'b01000,
		op_srli = 5'b01001,
		op_pass = 5'b11111
	} alu_op_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    dm_read;
		logic    dm_write;
		logic    reg_write;
	} ctrl_t;

	typedef struct packed {
		logic [xlen-1:0] instr;
		logic [pc_w-1:0] pc;
	} if_id_t;

	typedef struct packed {
		ctrl_t             ctrl;
		logic [xlen-1:0]   src1;
		logic [xlen-1:0]   src2;
		logic [xlen-1:0]   store_data;
		logic [reg_aw-1:0] rd;
	} id_ex_t;

	typedef struct packed {
		ctrl_t             ctrl;
		logic [xlen-1:0]   result;
		logic [xlen-1:0]   store_data;
		logic [reg_aw-1:0] rd;
	} ex_mem_t;

	typedef struct packed {
		logic              reg_write;
		logic [reg_aw-1:0] rd;
		logic [xlen-1:0]   data;
	} mem_wb_t;

endpackage

/* alu.sv */
`timescale 1ns/10ps

module alu (
	input  logic [cpu_pkg::xlen-1:0] a,
	input  logic [cpu_pkg::xlen-1:0] b,
	input  cpu_pkg::alu_op_e         op,
	output logic [cpu_pkg::xlen-1:0] result,
	output logic                     overflow
);

	always_comb begin
		overflow = 1'b0;
		case (op)
			cpu_pkg::op_add: begin
				result = a + b;
				// same-sign operands, result sign flipped
				overflow = (a[31] == b[31]) && (result[31] != a[31]);
			end
			cpu_pkg::op_sub: begin
				result = a - b;
				overflow = (a[31] != b[31]) && (result[31] != a[31]);
			end
			cpu_pkg::op_and:  result = a & b;
			cpu_pkg::op_or:   result = a | b;
			cpu_pkg::op_xor:  result = a ^ b;
			cpu_pkg::op_slli: result = a << b[4:0];
			cpu_pkg::op_srli: result = a >> b[4:0];
			cpu_pkg::op_pass: result = b;
			default:          result = '0;
		endcase
	end

endmodule

/* regfile.sv */
`timescale 1ns/10ps

module regfile (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [cpu_pkg::reg_aw-1:0] ra_addr,
	input  logic [cpu_pkg::reg_aw-1:0] rb_addr,
	input  logic [cpu_pkg::reg_aw-1:0] rt_addr,
	output logic [cpu_pkg::xlen-1:0]   ra_data,
	output logic [cpu_pkg::xlen-1:0]   rb_data,
	output logic [cpu_pkg::xlen-1:0]   rt_data,
	input  logic                       wr_en,
	input  logic [cpu_pkg::reg_aw-1:0] wr_addr,
	input  logic [cpu_pkg::xlen-1:0]   wr_data
);

	logic [cpu_pkg::xlen-1:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// no internal bypass, forward covers the write-back case
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

/* controller.sv */
`timescale 1ns/10ps

module controller (
	input  logic [cpu_pkg::xlen-1:0] instr,
	output cpu_pkg::ctrl_t           ctrl,
	output logic [cpu_pkg::xlen-1:0] imm
);

	cpu_pkg::opcode_e opcode;
	cpu_pkg::alu_op_e sub_op;

	assign opcode = cpu_pkg::opcode_e'(instr[30:25]);
	assign sub_op = cpu_pkg::alu_op_e'(instr[4:0]);

	always_comb begin
		ctrl = '0;
		imm = '0;
		case (opcode)
			cpu_pkg::alu_reg: begin
				case (sub_op)
					cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
					cpu_pkg::op_or, cpu_pkg::op_xor: begin
						ctrl.alu_op = sub_op;
						ctrl.reg_write = 1'b1;
					end
					cpu_pkg::op_slli, cpu_pkg::op_srli: begin
						// shift amount sits in the rb field
						ctrl.alu_op = sub_op;
						ctrl.use_imm = 1'b1;
						ctrl.reg_write = 1'b1;
						imm = {27'd0, instr[14:10]};
					end
					default: ;
				endcase
			end
			cpu_pkg::addi: begin
				ctrl.alu_op = cpu_pkg::op_add;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = {{17{instr[14]}}, instr[14:0]};
			end
			cpu_pkg::movi: begin
				ctrl.alu_op = cpu_pkg::op_pass;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = {{12{instr[19]}}, instr[19:0]};
			end
			cpu_pkg::lwi: begin
				ctrl.alu_op = cpu_pkg::op_add;
				ctrl.use_imm = 1'b1;
				ctrl.dm_read = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = {{17{instr[14]}}, instr[14:0]};
			end
			cpu_pkg::swi: begin
				ctrl.alu_op = cpu_pkg::op_add;
				ctrl.use_imm = 1'b1;
				ctrl.dm_write = 1'b1;
				imm = {{17{instr[14]}}, instr[14:0]};
			end
			// branches are resolved in pc_unit and write nothing
			default: ;
		endcase
	end

endmodule

/* pc_unit.sv */
`timescale 1ns/10ps

module pc_unit (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     enable,
	input  logic                     hold,
	input  cpu_pkg::if_id_t          if_id,
	input  logic [cpu_pkg::xlen-1:0] ra_val,
	input  logic [cpu_pkg::xlen-1:0] rt_val,
	output logic [cpu_pkg::pc_w-1:0] pc,
	output logic                     flush
);

	cpu_pkg::opcode_e opcode;
	logic [cpu_pkg::pc_w-1:0] offset;
	logic [cpu_pkg::pc_w-1:0] target;
	logic taken;

	assign opcode = cpu_pkg::opcode_e'(if_id.instr[30:25]);

	// 14-bit and 24-bit word offsets both wrap to the low pc bits
	assign offset = if_id.instr[cpu_pkg::pc_w-1:0];
	assign target = if_id.pc + offset;

	always_comb begin
		case (opcode)
			cpu_pkg::beq: taken = (rt_val == ra_val);
			cpu_pkg::bne: taken = (rt_val != ra_val);
			cpu_pkg::j:   taken = 1'b1;
			default:      taken = 1'b0;
		endcase
		// operands may still be in flight from a load
		taken = taken && !hold;
	end

	assign flush = taken;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (enable) begin
			if (taken)
				pc <= target;
			else if (!hold)
				pc <= pc + 1'b1;
		end
	end

endmodule

/* forward.sv */
`timescale 1ns/10ps

module forward (
	input  logic [cpu_pkg::reg_aw-1:0] ra_addr,
	input  logic [cpu_pkg::reg_aw-1:0] rb_addr,
	input  logic [cpu_pkg::reg_aw-1:0] rt_addr,
	input  logic [cpu_pkg::xlen-1:0]   ra_raw,
	input  logic [cpu_pkg::xlen-1:0]   rb_raw,
	input  logic [cpu_pkg::xlen-1:0]   rt_raw,
	input  cpu_pkg::id_ex_t            id_ex,
	input  logic [cpu_pkg::xlen-1:0]   ex_result,
	input  cpu_pkg::ex_mem_t           ex_mem,
	input  logic [cpu_pkg::xlen-1:0]   mem_result,
	input  cpu_pkg::mem_wb_t           mem_wb,
	output logic [cpu_pkg::xlen-1:0]   ra_val,
	output logic [cpu_pkg::xlen-1:0]   rb_val,
	output logic [cpu_pkg::xlen-1:0]   rt_val,
	output logic                       load_use
);

	logic ex_wr;

	// a load in execute has no value yet, load_use covers it
	assign ex_wr = id_ex.ctrl.reg_write && !id_ex.ctrl.dm_read;

	// youngest writer wins
	function automatic logic [cpu_pkg::xlen-1:0] pick(
		input logic [cpu_pkg::reg_aw-1:0] addr,
		input logic [cpu_pkg::xlen-1:0]   raw
	);
		if (ex_wr && id_ex.rd == addr)
			return ex_result;
		else if (ex_mem.ctrl.reg_write && ex_mem.rd == addr)
			return mem_result;
		else if (mem_wb.reg_write && mem_wb.rd == addr)
			return mem_wb.data;
		return raw;
	endfunction

	always_comb begin
		ra_val = pick(ra_addr, ra_raw);
		rb_val = pick(rb_addr, rb_raw);
		rt_val = pick(rt_addr, rt_raw);
	end

	assign load_use = id_ex.ctrl.dm_read && id_ex.ctrl.reg_write &&
		(id_ex.rd == ra_addr || id_ex.rd == rb_addr || id_ex.rd == rt_addr);

endmodule

/* regwalls.sv */
`timescale 1ns/10ps

module regwalls (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              enable,
	input  logic              flush,
	input  logic              load_use,
	input  cpu_pkg::if_id_t   if_in,
	input  cpu_pkg::id_ex_t   id_in,
	input  cpu_pkg::ex_mem_t  ex_in,
	input  cpu_pkg::mem_wb_t  mem_in,
	output cpu_pkg::if_id_t   if_id,
	output cpu_pkg::id_ex_t   id_ex,
	output cpu_pkg::ex_mem_t  ex_mem,
	output cpu_pkg::mem_wb_t  mem_wb
);

	// wall 1: all-zero instruction decodes as a no-op
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			if_id <= '0;
		else if (enable) begin
			if (flush)
				if_id <= '0;
			else if (!load_use)
				if_id <= if_in;
		end
	end

	// wall 2: bubble while the load result is pending
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			id_ex <= '0;
		else if (enable) begin
			if (load_use)
				id_ex <= '0;
			else
				id_ex <= id_in;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
			mem_wb <= '0;
		end else if (enable) begin
			ex_mem <= ex_in;
			mem_wb <= mem_in;
		end
	end

endmodule

/* dcache.sv */
`timescale 1ns/10ps

module dcache #(
	parameter int dcache_lines = 16
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      p_strobe,
	input  logic                      p_write,
	input  logic [cpu_pkg::dm_aw-1:0] p_addr,
	input  logic [cpu_pkg::xlen-1:0]  p_wdata,
	output logic [cpu_pkg::xlen-1:0]  p_rdata,
	output logic                      ready,
	output logic                      dm_enable,
	output logic                      dm_write,
	output logic [cpu_pkg::dm_aw-1:0] dm_addr,
	output logic [cpu_pkg::xlen-1:0]  dm_wdata,
	input  logic [cpu_pkg::xlen-1:0]  dm_rdata,
	input  logic                      dm_ack
);

	localparam int index_w = $clog2(dcache_lines);
	localparam int tag_w = cpu_pkg::dm_aw - index_w;

	typedef enum logic [1:0] {
		idle,
		read_miss,
		write_through
	} state_e;

	state_e state;
	logic done;
	logic [dcache_lines-1:0] valid;
	logic [tag_w-1:0] tags [dcache_lines];
	logic [cpu_pkg::xlen-1:0] data [dcache_lines];
	logic [index_w-1:0] p_index;
	logic [index_w-1:0] m_index;
	logic [tag_w-1:0] p_tag;
	logic [tag_w-1:0] m_tag;
	logic hit;
	logic start;

	assign p_index = p_addr[index_w-1:0];
	assign p_tag = p_addr[cpu_pkg::dm_aw-1:index_w];
	assign m_index = dm_addr[index_w-1:0];
	assign m_tag = dm_addr[cpu_pkg::dm_aw-1:index_w];

	assign hit = valid[p_index] && (tags[p_index] == p_tag);
	// done marks the request that just finished, so it is not issued twice
	assign start = (state == idle) && p_strobe && !done && (p_write || !hit);
	assign ready = (state == idle) && !start;
	assign p_rdata = data[p_index];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			done <= 1'b0;
			valid <= '0;
			dm_enable <= 1'b0;
			dm_write <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						dm_enable <= 1'b1;
						dm_write <= p_write;
						if (p_write) begin
							// write-allocate
							valid[p_index] <= 1'b1;
							state <= write_through;
						end else begin
							state <= read_miss;
						end
					end else if (p_strobe) begin
						done <= 1'b0;
					end
				end
				read_miss: begin
					if (dm_ack) begin
						valid[m_index] <= 1'b1;
						dm_enable <= 1'b0;
						done <= 1'b1;
						state <= idle;
					end
				end
				write_through: begin
					if (dm_ack) begin
						dm_enable <= 1'b0;
						done <= 1'b1;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			dm_addr <= p_addr;
			dm_wdata <= p_wdata;
		end
		if (start && p_write) begin
			data[p_index] <= p_wdata;
			tags[p_index] <= p_tag;
		end
		// line fill
		if (state == read_miss && dm_ack) begin
			data[m_index] <= dm_rdata;
			tags[m_index] <= m_tag;
		end
	end

endmodule

/* cpu_top.sv */
`timescale 1ns/10ps

module cpu_top #(
	parameter int dcache_lines = 16
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [cpu_pkg::xlen-1:0]  instruction,
	input  logic                      do_system,
	output logic                      im_enable,
	output logic [cpu_pkg::pc_w-1:0]  im_addr,
	output logic                      dm_enable,
	output logic                      dm_write,
	output logic [cpu_pkg::dm_aw-1:0] dm_addr,
	output logic [cpu_pkg::xlen-1:0]  dm_wdata,
	input  logic [cpu_pkg::xlen-1:0]  dm_rdata,
	input  logic                      dm_ack,
	output logic                      alu_overflow
);

	logic enable;
	logic c_ready;
	logic flush;
	logic load_use;
	logic [cpu_pkg::pc_w-1:0] pc;

	cpu_pkg::if_id_t  if_in, if_id;
	cpu_pkg::id_ex_t  id_in, id_ex;
	cpu_pkg::ex_mem_t ex_in, ex_mem;
	cpu_pkg::mem_wb_t mem_in, mem_wb;
	cpu_pkg::ctrl_t   ctrl;

	logic [cpu_pkg::reg_aw-1:0] ra_addr, rb_addr, rt_addr;
	logic [cpu_pkg::xlen-1:0] ra_raw, rb_raw, rt_raw;
	logic [cpu_pkg::xlen-1:0] ra_val, rb_val, rt_val;
	logic [cpu_pkg::xlen-1:0] imm;
	logic [cpu_pkg::xlen-1:0] ex_result;
	logic [cpu_pkg::xlen-1:0] mem_result;
	logic [cpu_pkg::xlen-1:0] p_rdata;
	logic p_strobe;

	assign enable = do_system && c_ready;
	assign im_enable = enable;
	assign im_addr = pc;

	// fetch
	assign if_in.instr = instruction;
	assign if_in.pc = pc;

	// decode
	assign ra_addr = if_id.instr[19:15];
	assign rb_addr = if_id.instr[14:10];
	assign rt_addr = if_id.instr[24:20];
	assign id_in.ctrl = ctrl;
	assign id_in.src1 = ra_val;
	assign id_in.src2 = ctrl.use_imm ? imm : rb_val;
	assign id_in.store_data = rt_val;
	assign id_in.rd = rt_addr;

	// execute
	assign ex_in.ctrl = id_ex.ctrl;
	assign ex_in.result = ex_result;
	assign ex_in.store_data = id_ex.store_data;
	assign ex_in.rd = id_ex.rd;

	// memory; no new request opens while the system is paused
	assign p_strobe = (ex_mem.ctrl.dm_read || ex_mem.ctrl.dm_write) && do_system;
	assign mem_result = ex_mem.ctrl.dm_read ? p_rdata : ex_mem.result;
	assign mem_in.reg_write = ex_mem.ctrl.reg_write;
	assign mem_in.rd = ex_mem.rd;
	assign mem_in.data = mem_result;

	controller u_controller (.instr(if_id.instr), .ctrl(ctrl), .imm(imm));

	regfile u_regfile (
		.clk(clk), .rst_n(rst_n),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.ra_data(ra_raw), .rb_data(rb_raw), .rt_data(rt_raw),
		.wr_en(mem_wb.reg_write && enable), .wr_addr(mem_wb.rd), .wr_data(mem_wb.data)
	);

	forward u_forward (
		.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.ra_raw(ra_raw), .rb_raw(rb_raw), .rt_raw(rt_raw),
		.id_ex(id_ex), .ex_result(ex_result),
		.ex_mem(ex_mem), .mem_result(mem_result), .mem_wb(mem_wb),
		.ra_val(ra_val), .rb_val(rb_val), .rt_val(rt_val),
		.load_use(load_use)
	);

	pc_unit u_pc_unit (
		.clk(clk), .rst_n(rst_n), .enable(enable), .hold(load_use),
		.if_id(if_id), .ra_val(ra_val), .rt_val(rt_val),
		.pc(pc), .flush(flush)
	);

	alu u_alu (
		.a(id_ex.src1), .b(id_ex.src2), .op(id_ex.ctrl.alu_op),
		.result(ex_result), .overflow(alu_overflow)
	);

	regwalls u_regwalls (
		.clk(clk), .rst_n(rst_n), .enable(enable), .flush(flush), .load_use(load_use),
		.if_in(if_in), .id_in(id_in), .ex_in(ex_in), .mem_in(mem_in),
		.if_id(if_id), .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb)
	);

	dcache #(.dcache_lines(dcache_lines)) u_dcache (
		.clk(clk), .rst_n(rst_n),
		.p_strobe(p_strobe), .p_write(ex_mem.ctrl.dm_write),
		.p_addr(ex_mem.result[13:2]), .p_wdata(ex_mem.store_data),
		.p_rdata(p_rdata), .ready(c_ready),
		.dm_enable(dm_enable), .dm_write(dm_write), .dm_addr(dm_addr),
		.dm_wdata(dm_wdata), .dm_rdata(dm_rdata), .dm_ack(dm_ack)
	);

endmodule

/* cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;

	localparam int lines = 16;
	localparam int n_prog = 5;
	localparam int prog_max = 64;
	localparam int acc_max = 24;
	localparam int timeout = 4000;

	typedef struct packed {
		logic        wr;
		logic [11:0] addr;
		logic [31:0] data;
	} txn_t;

	logic clk;
	logic rst_n;
	logic [31:0] instruction;
	logic do_system;
	logic im_enable;
	logic [9:0] im_addr;
	logic dm_enable;
	logic dm_write;
	logic [11:0] dm_addr;
	logic [31:0] dm_wdata;
	logic [31:0] dm_rdata;
	logic dm_ack;
	logic alu_overflow;

	// program table with code, data accesses in program order and run mode
	logic [31:0] prog [n_prog][prog_max];
	int prog_len [n_prog];
	txn_t acc [n_prog][acc_max];
	int acc_len [n_prog];
	logic pause_run [n_prog];
	logic ov_expect [n_prog];

	logic [31:0] mem [4096];
	txn_t seen [$];
	txn_t expect_q [$];
	int row;
	int delay;
	int span;
	logic end_seen;
	logic ov_seen;
	logic checking;
	logic prev_sys;
	logic prev_dm_en;
	logic prev_en;
	logic [9:0] prev_im;

	cpu_top #(.dcache_lines(lines)) u_dut (
		.clk(clk), .rst_n(rst_n), .instruction(instruction), .do_system(do_system),
		.im_enable(im_enable), .im_addr(im_addr),
		.dm_enable(dm_enable), .dm_write(dm_write), .dm_addr(dm_addr),
		.dm_wdata(dm_wdata), .dm_rdata(dm_rdata), .dm_ack(dm_ack),
		.alu_overflow(alu_overflow)
	);

	always #2 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("error: %s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	function automatic txn_t make_txn(input logic wr, input logic [11:0] addr,
		input logic [31:0] data);
		txn_t t;
		t.wr = wr;
		t.addr = addr;
		t.data = data;
		return t;
	endfunction

	// memory contents before any store
	function automatic logic [31:0] fill_word(input logic [11:0] a);
		return {a, 8'hc3, a};
	endfunction

	function automatic logic [31:0] enc_reg(input logic [4:0] op, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, cpu_pkg::alu_reg, rt, ra, rb, 5'd0, op};
	endfunction

	function automatic logic [31:0] enc_imm(input logic [5:0] opc, input logic [4:0] rt,
		input logic [4:0] ra, input logic [14:0] imm);
		return {1'b0, opc, rt, ra, imm};
	endfunction

	// loads and stores use r0 as base and a byte offset
	function automatic logic [31:0] enc_mem(input logic [5:0] opc, input logic [4:0] rt,
		input logic [11:0] word);
		return enc_imm(opc, rt, 5'd0, {1'b0, word, 2'b00});
	endfunction

	function automatic logic [31:0] enc_movi(input logic [4:0] rt, input logic [19:0] imm);
		return {1'b0, cpu_pkg::movi, rt, imm};
	endfunction

	function automatic logic [31:0] enc_branch(input logic [5:0] opc, input logic [4:0] rt,
		input logic [4:0] ra, input logic [13:0] off);
		return {1'b0, opc, rt, ra, 1'b0, off};
	endfunction

	function automatic logic [31:0] enc_jump(input logic [23:0] off);
		return {1'b0, cpu_pkg::j, 1'b0, off};
	endfunction

	task automatic put(input int r, input logic [31:0] ins);
		prog[r][prog_len[r]] = ins;
		prog_len[r] = prog_len[r] + 1;
	endtask

	task automatic note_access(input int r, input logic wr, input logic [11:0] addr,
		input logic [31:0] data);
		acc[r][acc_len[r]] = make_txn(wr, addr, data);
		acc_len[r] = acc_len[r] + 1;
	endtask

	task automatic end_program(input int r);
		put(r, enc_mem(cpu_pkg::swi, 5'd0, 12'hfff));
		note_access(r, 1'b1, 12'hfff, 32'd0);
	endtask

	task automatic build_loads(input int r);
		put(r, enc_movi(5'd1, 20'h01234));
		put(r, enc_mem(cpu_pkg::swi, 5'd1, 12'h020));
		put(r, enc_mem(cpu_pkg::lwi, 5'd2, 12'h020));
		put(r, enc_imm(cpu_pkg::addi, 5'd3, 5'd2, 15'd1));
		put(r, enc_mem(cpu_pkg::swi, 5'd3, 12'h021));
		put(r, enc_mem(cpu_pkg::lwi, 5'd4, 12'h045));
		put(r, enc_mem(cpu_pkg::swi, 5'd4, 12'h022));
		put(r, enc_mem(cpu_pkg::lwi, 5'd5, 12'h045));
		put(r, enc_mem(cpu_pkg::lwi, 5'd6, 12'h055));
		put(r, enc_mem(cpu_pkg::lwi, 5'd7, 12'h045));
		put(r, enc_reg(cpu_pkg::op_xor, 5'd8, 5'd6, 5'd7));
		put(r, enc_mem(cpu_pkg::swi, 5'd8, 12'h023));
		put(r, enc_mem(cpu_pkg::swi, 5'd5, 12'h024));
		put(r, enc_mem(cpu_pkg::lwi, 5'd9, 12'h030));
		put(r, enc_mem(cpu_pkg::lwi, 5'd10, 12'h020));
		put(r, enc_mem(cpu_pkg::swi, 5'd10, 12'h025));
		note_access(r, 1'b1, 12'h020, 32'h00001234);
		note_access(r, 1'b0, 12'h020, 32'd0);
		note_access(r, 1'b1, 12'h021, 32'h00001235);
		note_access(r, 1'b0, 12'h045, 32'd0);
		note_access(r, 1'b1, 12'h022, fill_word(12'h045));
		note_access(r, 1'b0, 12'h045, 32'd0);
		note_access(r, 1'b0, 12'h055, 32'd0);
		note_access(r, 1'b0, 12'h045, 32'd0);
		note_access(r, 1'b1, 12'h023, fill_word(12'h055) ^ fill_word(12'h045));
		note_access(r, 1'b1, 12'h024, fill_word(12'h045));
		note_access(r, 1'b0, 12'h030, 32'd0);
		note_access(r, 1'b0, 12'h020, 32'd0);
		note_access(r, 1'b1, 12'h025, 32'h00001234);
		end_program(r);
	endtask

	task automatic build_table;
		int r;
		for (r = 0; r < n_prog; r++) begin
			prog_len[r] = 0;
			acc_len[r] = 0;
			pause_run[r] = 1'b0;
			ov_expect[r] = 1'b0;
			for (int k = 0; k < prog_max; k++)
				prog[r][k] = '0;
		end
		// dependent ALU chain without spacing
		put(0, enc_movi(5'd1, 20'd100));
		put(0, enc_movi(5'd2, 20'd7));
		put(0, enc_reg(cpu_pkg::op_add, 5'd3, 5'd1, 5'd2));
		put(0, enc_reg(cpu_pkg::op_sub, 5'd4, 5'd3, 5'd2));
		put(0, enc_reg(cpu_pkg::op_and, 5'd5, 5'd4, 5'd3));
		put(0, enc_reg(cpu_pkg::op_or, 5'd6, 5'd5, 5'd2));
		put(0, enc_reg(cpu_pkg::op_xor, 5'd7, 5'd6, 5'd1));
		put(0, enc_reg(cpu_pkg::op_slli, 5'd8, 5'd7, 5'd4));
		put(0, enc_reg(cpu_pkg::op_srli, 5'd9, 5'd8, 5'd2));
		put(0, enc_imm(cpu_pkg::addi, 5'd10, 5'd9, 15'h7ffb));
		put(0, enc_mem(cpu_pkg::swi, 5'd10, 12'h008));
		put(0, enc_reg(cpu_pkg::op_sub, 5'd11, 5'd2, 5'd1));
		put(0, enc_mem(cpu_pkg::swi, 5'd11, 12'h009));
		put(0, enc_mem(cpu_pkg::swi, 5'd3, 12'h001));
		put(0, enc_mem(cpu_pkg::swi, 5'd4, 12'h002));
		put(0, enc_mem(cpu_pkg::swi, 5'd5, 12'h003));
		put(0, enc_mem(cpu_pkg::swi, 5'd6, 12'h004));
		put(0, enc_mem(cpu_pkg::swi, 5'd7, 12'h005));
		put(0, enc_mem(cpu_pkg::swi, 5'd8, 12'h006));
		put(0, enc_mem(cpu_pkg::swi, 5'd9, 12'h007));
		note_access(0, 1'b1, 12'h008, 32'd7);
		note_access(0, 1'b1, 12'h009, 32'hffffffa3);
		note_access(0, 1'b1, 12'h001, 32'd107);
		note_access(0, 1'b1, 12'h002, 32'd100);
		note_access(0, 1'b1, 12'h003, 32'h60);
		note_access(0, 1'b1, 12'h004, 32'h67);
		note_access(0, 1'b1, 12'h005, 32'h03);
		note_access(0, 1'b1, 12'h006, 32'h30);
		note_access(0, 1'b1, 12'h007, 32'h0c);
		end_program(0);
		build_loads(1);
		// branch offsets count from the branch itself
		put(2, enc_movi(5'd1, 20'd5));
		put(2, enc_movi(5'd2, 20'd5));
		put(2, enc_movi(5'd3, 20'd9));
		put(2, enc_branch(cpu_pkg::beq, 5'd1, 5'd2, 14'd2));
		put(2, enc_mem(cpu_pkg::swi, 5'd3, 12'h040));
		put(2, enc_mem(cpu_pkg::swi, 5'd1, 12'h041));
		put(2, enc_branch(cpu_pkg::bne, 5'd1, 5'd2, 14'd2));
		put(2, enc_mem(cpu_pkg::swi, 5'd2, 12'h042));
		put(2, enc_jump(24'd2));
		put(2, enc_mem(cpu_pkg::swi, 5'd3, 12'h043));
		put(2, enc_imm(cpu_pkg::addi, 5'd4, 5'd3, 15'd1));
		put(2, enc_branch(cpu_pkg::beq, 5'd4, 5'd3, 14'd2));
		put(2, enc_mem(cpu_pkg::swi, 5'd4, 12'h044));
		put(2, enc_branch(cpu_pkg::bne, 5'd4, 5'd3, 14'd3));
		put(2, enc_mem(cpu_pkg::swi, 5'd3, 12'h045));
		put(2, enc_mem(cpu_pkg::swi, 5'd3, 12'h046));
		put(2, enc_mem(cpu_pkg::swi, 5'd3, 12'h047));
		put(2, enc_mem(cpu_pkg::lwi, 5'd5, 12'h041));
		put(2, enc_branch(cpu_pkg::beq, 5'd5, 5'd1, 14'd2));
		put(2, enc_mem(cpu_pkg::swi, 5'd3, 12'h048));
		note_access(2, 1'b1, 12'h041, 32'd5);
		note_access(2, 1'b1, 12'h042, 32'd5);
		note_access(2, 1'b1, 12'h044, 32'd10);
		note_access(2, 1'b1, 12'h047, 32'd9);
		note_access(2, 1'b0, 12'h041, 32'd0);
		end_program(2);
		build_loads(3);
		pause_run[3] = 1'b1;
		// 0x7fffffff + 1
		put(4, enc_movi(5'd1, 20'hfffff));
		put(4, enc_reg(cpu_pkg::op_srli, 5'd1, 5'd1, 5'd1));
		put(4, enc_movi(5'd2, 20'd1));
		put(4, enc_reg(cpu_pkg::op_add, 5'd3, 5'd1, 5'd2));
		put(4, enc_mem(cpu_pkg::swi, 5'd3, 12'h010));
		note_access(4, 1'b1, 12'h010, 32'h80000000);
		end_program(4);
		ov_expect[4] = 1'b1;
	endtask

	// direct-mapped model where stores always go out and loads only on a miss
	task automatic predict(input int r);
		logic v [lines];
		logic [11:0] at [lines];
		txn_t a;
		int idx;
		int k;
		expect_q.delete();
		for (k = 0; k < lines; k++)
			v[k] = 1'b0;
		for (k = 0; k < acc_len[r]; k++) begin
			a = acc[r][k];
			idx = int'(a.addr) % lines;
			if (a.wr || !v[idx] || at[idx] != a.addr)
				expect_q.push_back(make_txn(a.wr, a.addr, a.wr ? a.data : 32'd0));
			v[idx] = 1'b1;
			at[idx] = a.addr;
		end
	endtask

	task automatic apply_reset;
		int i;
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		for (i = 0; i < 16; i++) begin
			@(posedge clk);
			#1;
			check_value("dm_enable", 32'(dm_enable), 32'd0);
		end
		rst_n = 1'b1;
		check_value("im_addr", 32'(im_addr), 32'd0);
	endtask

	task automatic run_program(input int r);
		int i;
		checking = 1'b0;
		row = r;
		end_seen = 1'b0;
		delay = 0;
		span = 0;
		seen.delete();
		for (i = 0; i < 4096; i++)
			mem[i] = fill_word(12'(i));
		predict(r);
		apply_reset();
		@(posedge clk);
		ov_seen = 1'b0;
		checking = 1'b1;
		for (i = 0; i < timeout; i++) begin
			@(posedge clk);
			if (end_seen)
				break;
		end
		if (!end_seen)
			fail_run($sformatf("program %0d did not reach its end store", r));
		checking = 1'b0;
		check_value("transaction count", 32'(seen.size()), 32'(expect_q.size()));
		for (i = 0; i < expect_q.size(); i++) begin
			check_value("dm_write", 32'(seen[i].wr), 32'(expect_q[i].wr));
			check_value("dm_addr", 32'(seen[i].addr), 32'(expect_q[i].addr));
			if (expect_q[i].wr)
				check_value("dm_wdata", seen[i].data, expect_q[i].data);
		end
		check_value("alu_overflow", 32'(ov_seen), 32'(ov_expect[r]));
	endtask

	// memory model, fetch and do_system driven just after each edge
	always begin
		@(posedge clk);
		#1;
		if (alu_overflow)
			ov_seen = 1'b1;
		if (checking) begin
			// enable drops while paused, while a request is open and when one is launched
			check_value("im_enable", 32'(prev_en),
				32'(prev_sys && !prev_dm_en && !dm_enable));
			if (!prev_en)
				check_value("im_addr", 32'(im_addr), 32'(prev_im));
			if (!prev_sys && dm_enable && !prev_dm_en)
				fail_run("dm_enable rose while do_system was low");
		end
		prev_im = im_addr;
		prev_dm_en = dm_enable;
		if (dm_ack) begin
			dm_ack = 1'b0;
		end else if (dm_enable) begin
			if (delay == 0)
				delay = $urandom % 4 + 1;
			delay = delay - 1;
			if (delay == 0) begin
				dm_ack = 1'b1;
				if (dm_write) begin
					mem[dm_addr] = dm_wdata;
					seen.push_back(make_txn(1'b1, dm_addr, dm_wdata));
					if (dm_addr == 12'hfff)
						end_seen = 1'b1;
				end else begin
					dm_rdata = mem[dm_addr];
					seen.push_back(make_txn(1'b0, dm_addr, 32'd0));
				end
			end
		end
		if (pause_run[row]) begin
			if (span == 0) begin
				do_system = !do_system;
				span = $urandom % 6 + 1;
			end
			span = span - 1;
		end else begin
			do_system = 1'b1;
		end
		prev_sys = do_system;
		instruction = (im_addr < 10'd64) ? prog[row][im_addr[5:0]] : 32'd0;
		#1;
		prev_en = im_enable;
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		do_system = 1'b0;
		instruction = '0;
		dm_rdata = '0;
		dm_ack = 1'b0;
		row = 0;
		delay = 0;
		span = 0;
		end_seen = 1'b0;
		ov_seen = 1'b0;
		checking = 1'b0;
		prev_sys = 1'b0;
		prev_dm_en = 1'b0;
		prev_en = 1'b0;
		prev_im = '0;
		void'($urandom(70968));
		build_table();
		for (int r = 0; r < n_prog; r++)
			run_program(r);
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* compile.f */
cpu_pkg.sv
alu.sv
regfile.sv
controller.sv
pc_unit.sv
forward.sv
regwalls.sv
dcache.sv
cpu_top.sv
cpu_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module cpu_tb -f compile.f -o cpu_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } || grep -q "TEST PASSED" sim.log
